// ==== dv/alu_ref.svh ====
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// keep the low n bits of v, then extend from bit n-1
function automatic logic [`RV_XLEN-1:0] ext_bits(input logic [`RV_XLEN-1:0] v, input int n,
                                                 input bit sgn);
    if (sgn) begin
        return $signed(v << (`RV_XLEN - n)) >>> (`RV_XLEN - n);
    end
    return (v << (`RV_XLEN - n)) >> (`RV_XLEN - n);
endfunction

function automatic logic [`RV_XLEN-1:0] ref_ext(input rv_alu_pkg::ext_mode_e mode,
                                                input logic [`RV_XLEN-1:0] v);
    case (mode)
        rv_alu_pkg::SEXT32: return ext_bits(v, 32, 1'b1);
        rv_alu_pkg::ZEXT32: return ext_bits(v, 32, 1'b0);
        rv_alu_pkg::SEXT16: return ext_bits(v, 16, 1'b1);
        rv_alu_pkg::ZEXT16: return ext_bits(v, 16, 1'b0);
        rv_alu_pkg::SEXT8:  return ext_bits(v, 8, 1'b1);
        rv_alu_pkg::ZEXT8:  return ext_bits(v, 8, 1'b0);
        default:            return v;
    endcase
endfunction

function automatic logic [`RV_XLEN-1:0] ref_int(input rv_alu_pkg::alu_op_e op,
                                                input logic [`RV_XLEN-1:0] a,
                                                input logic [`RV_XLEN-1:0] b);
    logic [`RV_XLEN-1:0] r;
    r = '0;   // branches and the multiply group
    case (op)
        rv_alu_pkg::ADD:  r = a + b;
        rv_alu_pkg::ADDW: r = ext_bits(a + b, `RV_WLEN, 1'b1);
        rv_alu_pkg::SUB:  r = a - b;
        rv_alu_pkg::SUBW: r = ext_bits(a - b, `RV_WLEN, 1'b1);
        rv_alu_pkg::AND:  r = a & b;
        rv_alu_pkg::OR:   r = a | b;
        rv_alu_pkg::XOR:  r = a ^ b;
        rv_alu_pkg::SLL:  r = a << b[5:0];
        rv_alu_pkg::SLLW: r = ext_bits(a << b[4:0], `RV_WLEN, 1'b1);
        rv_alu_pkg::SRL:  r = a >> b[5:0];
        rv_alu_pkg::SRLW: r = ext_bits({32'h0, a[31:0]} >> b[4:0], `RV_WLEN, 1'b1);
        rv_alu_pkg::SRA:  r = $signed(a) >>> b[5:0];
        rv_alu_pkg::SRAW: r = $signed({a[31:0], 32'h0}) >>> {1'b1, b[4:0]};  // word on top
        rv_alu_pkg::SLT:  r = 64'($signed(a) < $signed(b));
        rv_alu_pkg::SLTU: r = 64'(a < b);
        rv_alu_pkg::DIVU: r = (b == '0) ? '1 : a / b;
        rv_alu_pkg::REMU: r = (b == '0) ? a : a % b;
        rv_alu_pkg::PASS: r = b;
        default:          r = '0;
    endcase
    return r;
endfunction

function automatic logic ref_taken(input rv_alu_pkg::alu_op_e op,
                                   input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b);
    case (op)
        rv_alu_pkg::BEQ:  return a == b;
        rv_alu_pkg::BNE:  return a != b;
        rv_alu_pkg::BLT:  return $signed(a) < $signed(b);
        rv_alu_pkg::BGE:  return $signed(a) >= $signed(b);
        rv_alu_pkg::BLTU: return a < b;
        rv_alu_pkg::BGEU: return a >= b;
        default:          return 1'b0;
    endcase
endfunction

function automatic logic [`RV_XLEN-1:0] ref_mul(input rv_alu_pkg::alu_op_e op,
                                                input logic [`RV_XLEN-1:0] a,
                                                input logic [`RV_XLEN-1:0] b);
    logic signed [127:0] ps;
    logic [127:0]        pu;
    ps = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
    pu = {64'h0, a} * {64'h0, b};
    case (op)
        rv_alu_pkg::MULH:  return ps[127:64];
        rv_alu_pkg::MULHU: return pu[127:64];
        rv_alu_pkg::MULW:  return ext_bits(ps[63:0], `RV_WLEN, 1'b1);
        default:           return ps[63:0];
    endcase
endfunction

`endif

// ==== dv/ex_alu_tb.sv ====
`include "rv_alu_settings.svh"

module ex_alu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  rst_n;
    rv_alu_pkg::alu_op_e   alu_op;
    rv_alu_pkg::ext_mode_e ext_mode;
    logic [`RV_XLEN-1:0]   src1;
    logic [`RV_XLEN-1:0]   src2;
    logic [`RV_XLEN-1:0]   result;
    logic                  cmp_taken;
    logic                  mul_done;
    logic [31:0]           lfsr_q = 32'h87b0c36b;

    rv_alu_pkg::alu_op_e comb_ops [23] = '{
        rv_alu_pkg::ADD, rv_alu_pkg::ADDW, rv_alu_pkg::SUB, rv_alu_pkg::SUBW,
        rv_alu_pkg::AND, rv_alu_pkg::OR, rv_alu_pkg::XOR, rv_alu_pkg::SLL, rv_alu_pkg::SLLW,
        rv_alu_pkg::SRL, rv_alu_pkg::SRLW, rv_alu_pkg::SRA, rv_alu_pkg::SRAW,
        rv_alu_pkg::SLT, rv_alu_pkg::SLTU, rv_alu_pkg::BEQ, rv_alu_pkg::BNE, rv_alu_pkg::BLT,
        rv_alu_pkg::BGE, rv_alu_pkg::BLTU, rv_alu_pkg::BGEU, rv_alu_pkg::DIVU, rv_alu_pkg::REMU
    };
    rv_alu_pkg::alu_op_e mul_ops [4] = '{
        rv_alu_pkg::MUL, rv_alu_pkg::MULH, rv_alu_pkg::MULHU, rv_alu_pkg::MULW
    };

    `include "alu_ref.svh"

    ex_alu ex_alu_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // done must drop after a single cycle
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) mul_done |=> !mul_done)
        else fail_run("mul_done stayed high for more than one cycle");

    // galois lfsr, one step per bit
    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v      = {v[62:0], lfsr_q[0]};
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [63:0] pick_operand();
        case (3'(next_bits(3)))
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return 64'h8000_0000_0000_0000;
            3'd3:    return next_bits(6);   // small shift count
            default: return next_bits(64);
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp)
            else fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic drive_inputs(input rv_alu_pkg::alu_op_e op, input rv_alu_pkg::ext_mode_e em,
                                input logic [63:0] a, input logic [63:0] b);
        @(negedge clk);
        alu_op   = op;
        ext_mode = em;
        src1     = a;
        src2     = b;
    endtask

    task automatic check_comb(input rv_alu_pkg::alu_op_e op, input rv_alu_pkg::ext_mode_e em,
                              input logic [63:0] a, input logic [63:0] b);
        drive_inputs(op, em, a, b);
        @(posedge clk);
        compare_value("result", result, ref_ext(em, ref_int(op, a, b)));
        compare_value("cmp_taken", 64'(cmp_taken), 64'(ref_taken(op, a, b)));
    endtask

    task automatic check_mul(input rv_alu_pkg::alu_op_e op, input logic [63:0] a,
                             input logic [63:0] b);
        logic seen;
        int   n;
        drive_inputs(op, rv_alu_pkg::NONE, a, b);
        seen = 1'b0;
        for (n = 0; n < 200 && !seen; n++) begin
            @(posedge clk);
            seen = mul_done;
        end
        if (!seen) begin
            fail_run("multiply never finished, no mul_done within 200 cycles");
        end
        compare_value("result", result, ref_mul(op, a, b));
        repeat (3) begin   // product held with the inputs
            @(posedge clk);
            compare_value("result", result, ref_mul(op, a, b));
            compare_value("mul_done", 64'(mul_done), 64'h0);
        end
    endtask

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        int          e;
        rst_n    = 1'b0;
        alu_op   = rv_alu_pkg::ADD;
        ext_mode = rv_alu_pkg::NONE;
        src1     = '0;
        src2     = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        compare_value("mul_done", 64'(mul_done), 64'h0);

        foreach (comb_ops[i]) begin
            repeat (24) begin
                a = pick_operand();
                b = (next_bits(2) == 64'd0) ? a : pick_operand();   // equal pairs for branches
                check_comb(comb_ops[i], rv_alu_pkg::NONE, a, b);
            end
        end
        check_comb(rv_alu_pkg::DIVU, rv_alu_pkg::NONE, next_bits(64), '0);
        check_comb(rv_alu_pkg::REMU, rv_alu_pkg::NONE, next_bits(64), '0);

        for (e = 0; e < 7; e++) begin
            repeat (8) begin
                b = pick_operand();
                check_comb(rv_alu_pkg::PASS, rv_alu_pkg::ext_mode_e'(3'(e)), next_bits(64), b);
            end
        end

        repeat (6) begin
            foreach (mul_ops[i]) begin
                a = pick_operand();
                b = pick_operand();
                check_mul(mul_ops[i], a, b);
                check_comb(rv_alu_pkg::ADD, rv_alu_pkg::NONE, a, b);
            end
        end
        check_mul(rv_alu_pkg::MULH, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build ex_alu_tb with Verilator and run it, exit status follows the simulation
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module ex_alu_tb -f tb.f -o ex_alu_sim &&
    ./obj_dir/ex_alu_sim ||
    { echo "ex_alu simulation failed"; exit 1; }

// ==== tb.f ====
+incdir+verilog
+incdir+dv
verilog/rv_alu_pkg.sv
verilog/mul_if.sv
verilog/int_alu.sv
verilog/seq_mul.sv
verilog/ex_alu.sv
dv/ex_alu_tb.sv

// ==== verilog/ex_alu.sv ====
`include "rv_alu_settings.svh"

module ex_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_alu_pkg::alu_op_e     alu_op,
    input  rv_alu_pkg::ext_mode_e   ext_mode,
    input  logic [`RV_XLEN-1:0]     src1,
    input  logic [`RV_XLEN-1:0]     src2,
    output logic [`RV_XLEN-1:0]     result,
    output logic                    cmp_taken,
    output logic                    mul_done
);
    localparam int XW = `RV_XLEN;

    logic [XW-1:0]         raw;
    logic                  is_mul;
    rv_alu_pkg::mul_mode_e req_mode;
    rv_alu_pkg::mul_mode_e mode_q;   // signedness of the outstanding request
    logic                  pend_q;   // started, waiting for done
    logic                  held_q;   // product in prod_q belongs to this request
    logic [2*XW-1:0]       prod_q;
    logic                  stale;
    logic                  mul_ok;
    logic [2*XW-1:0]       prod;
    logic [XW-1:0]         sel;

    mul_if u_mif ();

    int_alu u_int (
        .op    (alu_op),
        .src1  (src1),
        .src2  (src2),
        .raw   (raw),
        .taken (cmp_taken)
    );

    seq_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .m     (u_mif.mul)
    );

    always_comb begin
        is_mul   = 1'b1;
        req_mode = rv_alu_pkg::SS;
        case (alu_op)
            rv_alu_pkg::MUL,
            rv_alu_pkg::MULH,
            rv_alu_pkg::MULW:  req_mode = rv_alu_pkg::SS;
            rv_alu_pkg::MULHU: req_mode = rv_alu_pkg::UU;
            default:           is_mul = 1'b0;
        endcase
    end

    // a signedness change counts as a new request
    assign stale = !is_mul || (req_mode != mode_q);

    assign u_mif.start = is_mul && !u_mif.busy && (stale || !(pend_q || held_q));
    assign u_mif.mode  = req_mode;
    assign u_mif.a     = src1;
    assign u_mif.b     = src2;

    // done of an abandoned request is swallowed here
    assign mul_done = u_mif.done && pend_q && !stale;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            held_q <= 1'b0;
            mode_q <= rv_alu_pkg::SS;
            prod_q <= '0;
        end else if (u_mif.start) begin
            pend_q <= 1'b1;
            held_q <= 1'b0;
            mode_q <= req_mode;
        end else if (stale) begin
            pend_q <= 1'b0;
            held_q <= 1'b0;
        end else if (mul_done) begin
            pend_q <= 1'b0;
            held_q <= 1'b1;
            prod_q <= u_mif.product;
        end
    end

    assign mul_ok = !stale && (held_q || mul_done);
    assign prod   = held_q ? prod_q : u_mif.product;   // bypass in the done cycle

    always_comb begin
        sel = raw;   // zero for a multiply still in flight
        if (mul_ok) begin
            case (alu_op)
                rv_alu_pkg::MULH,
                rv_alu_pkg::MULHU: sel = prod[2*XW-1:XW];
                rv_alu_pkg::MULW:  sel = {{(XW-32){prod[31]}}, prod[31:0]};
                default:           sel = prod[XW-1:0];
            endcase
        end
    end

    always_comb begin
        case (ext_mode)
            rv_alu_pkg::SEXT32: result = {{(XW-32){sel[31]}}, sel[31:0]};
            rv_alu_pkg::ZEXT32: result = {{(XW-32){1'b0}}, sel[31:0]};
            rv_alu_pkg::SEXT16: result = {{(XW-16){sel[15]}}, sel[15:0]};
            rv_alu_pkg::ZEXT16: result = {{(XW-16){1'b0}}, sel[15:0]};
            rv_alu_pkg::SEXT8:  result = {{(XW-8){sel[7]}}, sel[7:0]};
            rv_alu_pkg::ZEXT8:  result = {{(XW-8){1'b0}}, sel[7:0]};
            default:            result = sel;
        endcase
    end

endmodule

// ==== verilog/int_alu.sv ====
`include "rv_alu_settings.svh"

module int_alu (
    input  rv_alu_pkg::alu_op_e   op,
    input  logic [`RV_XLEN-1:0]   src1,
    input  logic [`RV_XLEN-1:0]   src2,
    output logic [`RV_XLEN-1:0]   raw,
    output logic                  taken
);
    localparam int XW  = `RV_XLEN;
    localparam int WW  = `RV_WLEN;
    localparam int SH  = $clog2(XW);
    localparam int SHW = $clog2(WW);

    logic [WW-1:0]  w1;
    logic [WW-1:0]  w2;
    logic [WW-1:0]  w_res;    // 32-bit result before sign extension
    logic [SH-1:0]  shamt;
    logic [SHW-1:0] shamt_w;
    logic           eq;
    logic           lt;
    logic           ltu;

    function automatic logic [XW-1:0] sext_w(input logic [WW-1:0] v);
        return {{(XW-WW){v[WW-1]}}, v};
    endfunction

    assign w1      = src1[WW-1:0];
    assign w2      = src2[WW-1:0];
    assign shamt   = src2[SH-1:0];
    assign shamt_w = src2[SHW-1:0];

    // shared by branches and set-less-than
    assign eq  = (src1 == src2);
    assign lt  = ($signed(src1) < $signed(src2));
    assign ltu = (src1 < src2);

    always_comb begin
        raw   = '0;
        taken = 1'b0;
        w_res = '0;
        case (op)
            rv_alu_pkg::ADD:  raw = src1 + src2;
            rv_alu_pkg::SUB:  raw = src1 - src2;
            rv_alu_pkg::ADDW: begin
                w_res = w1 + w2;
                raw   = sext_w(w_res);
            end
            rv_alu_pkg::SUBW: begin
                w_res = w1 - w2;
                raw   = sext_w(w_res);
            end
            rv_alu_pkg::AND:  raw = src1 & src2;
            rv_alu_pkg::OR:   raw = src1 | src2;
            rv_alu_pkg::XOR:  raw = src1 ^ src2;
            rv_alu_pkg::SLL:  raw = src1 << shamt;
            rv_alu_pkg::SRL:  raw = src1 >> shamt;
            rv_alu_pkg::SRA:  raw = $signed(src1) >>> shamt;
            rv_alu_pkg::SLLW: begin
                w_res = w1 << shamt_w;
                raw   = sext_w(w_res);
            end
            rv_alu_pkg::SRLW: begin
                w_res = w1 >> shamt_w;   // zero fill, then sign of bit 31
                raw   = sext_w(w_res);
            end
            rv_alu_pkg::SRAW: begin
                w_res = $signed(w1) >>> shamt_w;
                raw   = sext_w(w_res);
            end
            rv_alu_pkg::SLT:  raw = XW'(lt);
            rv_alu_pkg::SLTU: raw = XW'(ltu);
            rv_alu_pkg::BEQ:  taken = eq;
            rv_alu_pkg::BNE:  taken = !eq;
            rv_alu_pkg::BLT:  taken = lt;
            rv_alu_pkg::BGE:  taken = !lt;
            rv_alu_pkg::BLTU: taken = ltu;
            rv_alu_pkg::BGEU: taken = !ltu;
            rv_alu_pkg::DIVU: begin
                // riscv rule, quotient of x/0 is all ones
                if (src2 == '0) begin
                    raw = '1;
                end else begin
                    raw = src1 / src2;
                end
            end
            rv_alu_pkg::REMU: begin
                if (src2 == '0) begin
                    raw = src1;      // remainder of x/0 is x
                end else begin
                    raw = src1 % src2;
                end
            end
            rv_alu_pkg::PASS: raw = src2;
            default: begin
                // multiply group, result comes from seq_mul
                raw   = '0;
                taken = 1'b0;
            end
        endcase
    end

endmodule

// ==== verilog/mul_if.sv ====
`include "rv_alu_settings.svh"

interface mul_if;
    logic                      start;     // one-cycle request pulse
    rv_alu_pkg::mul_mode_e     mode;
    logic [`RV_XLEN-1:0]       a;
    logic [`RV_XLEN-1:0]       b;
    logic [2*`RV_XLEN-1:0]     product;   // valid from done until next start
    logic                      busy;
    logic                      done;      // one-cycle pulse

    // execute side, issues the request and holds operands until done
    modport req (
        output start, mode, a, b,
        input  product, busy, done
    );

    modport mul (
        input  start, mode, a, b,
        output product, busy, done
    );

endinterface

// ==== verilog/rv_alu_pkg.sv ====
package rv_alu_pkg;

    // execute opcodes, the multiply group sits near the end
    typedef enum logic [4:0] {
        ADD,
        ADDW,
        SUB,
        SUBW,
        AND,
        OR,
        XOR,
        SLL,
        SLLW,
        SRL,
        SRLW,
        SRA,
        SRAW,
        SLT,
        SLTU,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        DIVU,
        REMU,
        MUL,
        MULH,
        MULHU,
        MULW,
        PASS    // load data arrives on src2
    } alu_op_e;

    // applied last, after the result select
    typedef enum logic [2:0] {
        NONE,
        SEXT32,
        ZEXT32,
        SEXT16,
        ZEXT16,
        SEXT8,
        ZEXT8
    } ext_mode_e;

    // one bit per operand, set when that operand is signed
    typedef enum logic [1:0] {
        UU = 2'b00,
        SS = 2'b11
    } mul_mode_e;

endpackage

// ==== verilog/rv_alu_settings.svh ====
`ifndef RV_ALU_SETTINGS_SVH
`define RV_ALU_SETTINGS_SVH

// datapath width of the core
`define RV_XLEN 64

// width seen by the W-suffix ops
`define RV_WLEN 32

// one shift-add per cycle, one step per multiplier bit
`define RV_MUL_STEPS 64

`endif

// ==== verilog/seq_mul.sv ====
`include "rv_alu_settings.svh"

module seq_mul (
    input  logic clk,
    input  logic rst_n,
    mul_if.mul   m
);
    localparam int XW    = `RV_XLEN;
    localparam int CNT_W = $clog2(`RV_MUL_STEPS);

    logic [XW-1:0]    mcand_q;   // multiplicand magnitude
    logic [XW-1:0]    hi_q;      // upper half of partial product
    logic [XW-1:0]    lo_q;      // multiplier bits shift out, product bits in
    logic             neg_q;
    logic [CNT_W-1:0] cnt_q;

    logic             signed_op;
    logic [XW-1:0]    a_mag;
    logic [XW-1:0]    b_mag;
    logic [XW:0]      sum;
    logic [XW-1:0]    hi_nxt;
    logic [XW-1:0]    lo_nxt;
    logic [2*XW-1:0]  mag;
    logic             last;
    logic             accept;

    assign signed_op = (m.mode == rv_alu_pkg::SS);

    // the most negative value still fits as an unsigned magnitude
    assign a_mag = (signed_op && m.a[XW-1]) ? -m.a : m.a;
    assign b_mag = (signed_op && m.b[XW-1]) ? -m.b : m.b;

    assign accept = m.start && !m.busy;
    assign last   = (cnt_q == CNT_W'(`RV_MUL_STEPS - 1));

    // one add and one right shift per step
    assign sum    = {1'b0, hi_q} + (lo_q[0] ? {1'b0, mcand_q} : '0);
    assign hi_nxt = sum[XW:1];
    assign lo_nxt = {sum[0], lo_q[XW-1:1]};
    assign mag    = {hi_nxt, lo_nxt};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m.busy <= 1'b0;
            m.done <= 1'b0;
            cnt_q  <= '0;
        end else begin
            m.done <= 1'b0;
            if (accept) begin
                m.busy <= 1'b1;
                cnt_q  <= '0;
            end else if (m.busy) begin
                cnt_q <= cnt_q + 1'b1;
                if (last) begin
                    m.busy <= 1'b0;
                    m.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mcand_q <= b_mag;
            lo_q    <= a_mag;
            hi_q    <= '0;
            neg_q   <= signed_op && (m.a[XW-1] ^ m.b[XW-1]);
        end else if (m.busy) begin
            hi_q <= hi_nxt;
            lo_q <= lo_nxt;
            if (last) begin
                m.product <= neg_q ? -mag : mag;   // sign applied once at the end
            end
        end
    end

endmodule
